/* files.f */
+incdir+verif
hw/pkt_fifo_pkg.sv
hw/pkt_fifo_ctrl.sv
hw/fifo_word_ram.sv
hw/fifo_out_stage.sv
hw/pkt_fifo_top.sv
verif/pkt_fifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs pkt_fifo_tb with Verilator, back-pressure off and then on.
# Each run is judged by the pass line in its own log.

cd "$(dirname "$0")" || exit 1

pass_line="=== PASS ==="
overall=0

run_mode() {
    local bp="$1"
    local obj="obj_dir_bp${bp}"
    local log="sim_bp${bp}.log"
    local sim_status

    verilator --binary --timing --timescale 1ns/1ps --top-module pkt_fifo_tb \
        -GALLOW_BACKPRESSURE="${bp}" -Mdir "${obj}" -f files.f
    if [ $? -ne 0 ]; then
        echo "build failed for ALLOW_BACKPRESSURE=${bp}"
        return 1
    fi

    "./${obj}/Vpkt_fifo_tb" > "${log}" 2>&1
    sim_status=$?
    cat "${log}"
    if [ "${sim_status}" -ne 0 ]; then
        echo "simulation returned status ${sim_status} for ALLOW_BACKPRESSURE=${bp}"
        return 1
    fi

    if grep -qxF "${pass_line}" "${log}"; then
        echo "ALLOW_BACKPRESSURE=${bp} passed"
        return 0
    fi
    echo "ALLOW_BACKPRESSURE=${bp} failed, see ${log}"
    return 1
}

for bp in 0 1; do
    if ! run_mode "${bp}"; then
        overall=1
    fi
done

exit ${overall}

/* verif/pkt_fifo_vectors.svh */
/* Packet scenarios, included inside the FIFO testbench after DEPTH is declared.
   Each row starts with an empty FIFO; rows without a stall stay under DEPTH-1 beats. */

`ifndef PKT_FIFO_VECTORS_SVH
`define PKT_FIFO_VECTORS_SVH

// columns of one row
//   name        test name shown on a mismatch
//   pkt_count   packets sent in the row
//   pkt_len     beats per packet, only the final beat carries last
//   stall       out_ready held low while the packets are written
//   rand_ready  out_ready taken from the LFSR once released
//   beats_nobp  delivered beats, back-pressure off
//   ovf_nobp    in_overflow pulses, back-pressure off
//   beats_bp    delivered beats, back-pressure on
//   ovf_bp      in_overflow pulses, back-pressure on
typedef struct {
    string name;
    int    pkt_count;
    int    pkt_len;
    bit    stall;
    bit    rand_ready;
    int    beats_nobp;
    int    ovf_nobp;
    int    beats_bp;
    int    ovf_bp;
} vector_t;

localparam int NUM_VECTORS = 6;

vector_t vectors [NUM_VECTORS];

task automatic load_vectors();
    // plain single packets
    vectors[0] = '{"one_beat", 1, 1, 1'b0, 1'b0, 1, 0, 1, 0};
    vectors[1] = '{"three_beats", 1, 3, 1'b0, 1'b0, 3, 0, 3, 0};
    vectors[2] = '{"five_beats", 1, 5, 1'b0, 1'b0, 5, 0, 5, 0};
    // reader throttled at random
    vectors[3] = '{"random_ready", 2, 3, 1'b0, 1'b1, 6, 0, 6, 0};
    // store holds DEPTH words while stalled, the rest is lost without back-pressure
    vectors[4] = '{"overflow_stall", 1, DEPTH + 3, 1'b1, 1'b0, DEPTH, 1, DEPTH + 3, 0};
    // intact packet right after the damaged one
    vectors[5] = '{"after_overflow", 1, 4, 1'b0, 1'b0, 4, 0, 4, 0};
endtask

`endif

/* verif/pkt_fifo_tb.sv */
/* Testbench for pkt_fifo_top with DEPTH 8 and the output register on.
   ALLOW_BACKPRESSURE comes from the build and selects the expected columns. */

`timescale 1ns/1ps

module pkt_fifo_tb #(
    parameter bit ALLOW_BACKPRESSURE = 1'b0
);
    import pkt_fifo_pkg::*;

    localparam int DEPTH      = 8;
    localparam bit OUTPUT_REG = 1'b1;
    localparam int CLK_HALF   = 2;

    `include "pkt_fifo_vectors.svh"

    //////////////////////////////
    // DUT and testbench state
    //////////////////////////////

    logic        axis_out;
    logic        reset = 1'b1;
    axis_word_t  in_word;
    logic        in_valid;
    logic        in_ready;
    axis_word_t  out_word;
    logic        out_valid;
    logic        out_ready;
    logic        in_overflow;
    logic        out_overflow;

    axis_word_t  exp_q [$];
    logic [15:0] data_lfsr  = 16'd53;
    logic [15:0] ready_lfsr = 16'd53;
    bit          writes_done;
    bit          ready_low_seen;
    bit          oflag_seen;
    int          ovf_count;
    int          model_ovf;
    int          model_kept;

    pkt_fifo_top #(
        .DEPTH              (DEPTH),
        .OUTPUT_REG         (OUTPUT_REG),
        .ALLOW_BACKPRESSURE (ALLOW_BACKPRESSURE)
    ) u_dut (
        .axis_out     (axis_out),
        .reset        (reset),
        .in_word      (in_word),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .out_word     (out_word),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .in_overflow  (in_overflow),
        .out_overflow (out_overflow)
    );

    initial begin
        axis_out = 1'b0;
        forever #CLK_HALF axis_out = ~axis_out;
    end

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // one lfsr step per payload bit
    task automatic make_word(input logic last, output axis_word_t w);
        for (int i = 0; i < DATA_BYTES * 8; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            w.data[i] = data_lfsr[0];
        end
        for (int i = 0; i < DATA_BYTES; i++) begin
            data_lfsr = lfsr_step(data_lfsr);
            w.keep[i] = data_lfsr[0];
        end
        w.last = last;
    endtask

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    //////////////////////////////
    // driver with queue model
    //////////////////////////////

    task automatic send_row(input vector_t v);
        axis_word_t w;
        int         held;
        bit         dropping;
        bit         damaged;
        bit         accepted;
        held     = 0;
        dropping = 1'b0;
        damaged  = 1'b0;
        for (int p = 0; p < v.pkt_count; p++) begin
            for (int b = 0; b < v.pkt_len; b++) begin
                make_word(b == v.pkt_len - 1, w);
                in_word  = w;
                in_valid = 1'b1;
                accepted = 1'b0;
                while (!accepted) begin
                    @(negedge axis_out);
                    accepted = in_ready;
                    if (!in_ready) begin
                        ready_low_seen = 1'b1;
                    end
                    @(posedge axis_out);
                    #1;
                end
                // a stalled store keeps DEPTH words, then the packet tail is lost
                if (!ALLOW_BACKPRESSURE && v.stall && (dropping || held >= DEPTH)) begin
                    damaged  = 1'b1;
                    dropping = !w.last;
                end else begin
                    exp_q.push_back(w);
                    held++;
                    model_kept++;
                end
                if (w.last) begin
                    if (damaged) begin
                        model_ovf++;
                    end
                    damaged = 1'b0;
                end
            end
        end
        in_valid    = 1'b0;
        writes_done = 1'b1;
    endtask

    //////////////////////////////
    // output monitor
    //////////////////////////////

    task automatic receive_row(input vector_t v, input int exp_beats);
        int         got;
        bit         prev_stalled;
        axis_word_t prev_word;
        got          = 0;
        prev_stalled = 1'b0;
        prev_word    = '0;
        while (got < exp_beats) begin
            @(negedge axis_out);
            if (prev_stalled) begin
                compare_value({v.name, " held valid"}, 64'd1, 64'(out_valid));
                compare_value({v.name, " held word"}, 64'(prev_word), 64'(out_word));
            end
            prev_stalled = out_valid && !out_ready;
            prev_word    = out_word;
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("%s: DUT delivered a beat that the model did not keep", v.name);
                    $display("=== FAIL ===");
                    $fatal(1, "unexpected beat");
                end else begin
                    compare_value({v.name, " beat"}, 64'(exp_q[0]), 64'(out_word));
                    void'(exp_q.pop_front());
                    got++;
                end
            end
            if (got < exp_beats) begin
                @(posedge axis_out);
                #1;
                // stall ends when writing is over or the writer is blocked
                if (v.stall && !writes_done && !ready_low_seen) begin
                    out_ready = 1'b0;
                end else if (v.rand_ready) begin
                    ready_lfsr = lfsr_step(ready_lfsr);
                    out_ready  = ready_lfsr[0];
                end else begin
                    out_ready = 1'b1;
                end
            end
        end
    endtask

    task automatic run_vector(input vector_t v);
        int exp_beats;
        int exp_ovf;
        exp_beats      = ALLOW_BACKPRESSURE ? v.beats_bp : v.beats_nobp;
        exp_ovf        = ALLOW_BACKPRESSURE ? v.ovf_bp : v.ovf_nobp;
        writes_done    = 1'b0;
        ready_low_seen = 1'b0;
        oflag_seen     = 1'b0;
        ovf_count      = 0;
        model_ovf      = 0;
        model_kept     = 0;
        out_ready      = !v.stall;
        fork
            send_row(v);
            receive_row(v, exp_beats);
        join
        @(posedge axis_out);
        #1;
        out_ready = 1'b1;
        // once drained nothing may follow
        repeat (3) begin
            @(negedge axis_out);
            compare_value({v.name, " extra beat"}, 64'd0, 64'(out_valid));
        end
        @(posedge axis_out);
        #1;
        compare_value({v.name, " kept beats"}, 64'(exp_beats), 64'(model_kept));
        compare_value({v.name, " model overflow"}, 64'(exp_ovf), 64'(model_ovf));
        compare_value({v.name, " left in model"}, 64'd0, 64'(exp_q.size()));
        compare_value({v.name, " in_overflow pulses"}, 64'(exp_ovf), 64'(ovf_count));
        compare_value({v.name, " out_overflow seen"}, 64'(exp_ovf != 0), 64'(oflag_seen));
        compare_value({v.name, " in_ready low"}, 64'(ALLOW_BACKPRESSURE && v.stall),
                      64'(ready_low_seen));
    endtask

    // loss flags sampled mid cycle
    initial begin
        forever begin
            @(negedge axis_out);
            if (!reset) begin
                if (in_overflow) begin
                    ovf_count++;
                end
                if (out_overflow) begin
                    oflag_seen = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        int limit;
        @(negedge reset);
        limit = 0;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            limit += vectors[i].pkt_count * vectors[i].pkt_len * 20;
        end
        repeat (limit) @(posedge axis_out);
        $display("Timeout: expected beats were not delivered within %0d cycles", limit);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    initial begin
        in_word   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        reset     = 1'b1;
        load_vectors();
        repeat (4) @(posedge axis_out);
        #1;
        reset = 1'b0;
        // idle outputs right after reset
        @(negedge axis_out);
        compare_value("after_reset out_valid", 64'd0, 64'(out_valid));
        compare_value("after_reset in_overflow", 64'd0, 64'(in_overflow));
        compare_value("after_reset out_overflow", 64'd0, 64'(out_overflow));
        @(posedge axis_out);
        #1;
        for (int i = 0; i < NUM_VECTORS; i++) begin
            run_vector(vectors[i]);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* hw/pkt_fifo_top.sv */
/* Single clock packet FIFO for a byte-lane stream. Without back-pressure an overflow
   truncates the packet in flight and the stored head still reaches the reader. */

`timescale 1ns/1ps

module pkt_fifo_top #(
    parameter int DEPTH              = 64,
    parameter bit OUTPUT_REG         = 1'b1,
    parameter bit ALLOW_BACKPRESSURE = 1'b0
) (
    input  logic                     axis_out,
    input  logic                     reset,

    // input stream
    input  pkt_fifo_pkg::axis_word_t in_word,
    input  logic                     in_valid,
    output logic                     in_ready,

    // output stream
    output pkt_fifo_pkg::axis_word_t out_word,
    output logic                     out_valid,
    input  logic                     out_ready,

    // loss flags
    output logic                     in_overflow,
    output logic                     out_overflow
);
    import pkt_fifo_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);

    //////////////////////////////
    // internal wiring
    //////////////////////////////

    logic              wr_en;
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic              empty;
    logic              pop;
    axis_word_t        rd_word;

    //////////////////////////////
    // blocks
    //////////////////////////////

    pkt_fifo_ctrl #(
        .DEPTH              (DEPTH),
        .ALLOW_BACKPRESSURE (ALLOW_BACKPRESSURE)
    ) u_ctrl (
        .axis_out     (axis_out),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_last      (in_word.last),
        .in_ready     (in_ready),
        .wr_en        (wr_en),
        .wr_ptr       (wr_ptr),
        .pop          (pop),
        .rd_ptr       (rd_ptr),
        .empty        (empty),
        .in_overflow  (in_overflow),
        .out_overflow (out_overflow)
    );

    fifo_word_ram #(
        .DEPTH (DEPTH)
    ) u_ram (
        .axis_out (axis_out),
        .wr_en    (wr_en),
        .wr_ptr   (wr_ptr),
        .wr_word  (in_word),
        .rd_ptr   (rd_ptr),
        .rd_word  (rd_word)
    );

    fifo_out_stage #(
        .OUTPUT_REG (OUTPUT_REG)
    ) u_out (
        .axis_out  (axis_out),
        .reset     (reset),
        .rd_word   (rd_word),
        .empty     (empty),
        .pop       (pop),
        .out_word  (out_word),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

/* hw/fifo_out_stage.sv */
/* Output side of the FIFO. With OUTPUT_REG the head is prefetched into a register,
   which adds one cycle of latency and one word of capacity. */

`timescale 1ns/1ps

module fifo_out_stage #(
    parameter bit OUTPUT_REG = 1'b1
) (
    input  logic                     axis_out,
    input  logic                     reset,

    // head of the RAM
    input  pkt_fifo_pkg::axis_word_t rd_word,
    input  logic                     empty,
    output logic                     pop,

    // output stream
    output pkt_fifo_pkg::axis_word_t out_word,
    output logic                     out_valid,
    input  logic                     out_ready
);
    import pkt_fifo_pkg::*;

    generate
        if (OUTPUT_REG) begin : reg_g

            //////////////////////////////
            // registered prefetch
            //////////////////////////////

            axis_word_t word_q;
            logic       valid_q;
            logic       load;

            // register is free or leaves on this edge
            assign load = !empty && (!valid_q || out_ready);

            always_ff @(posedge axis_out) begin
                if (reset) begin
                    valid_q <= 1'b0;
                end else if (load) begin
                    valid_q <= 1'b1;
                end else if (out_ready) begin
                    // drained and nothing behind it
                    valid_q <= 1'b0;
                end
            end

            // payload only
            always_ff @(posedge axis_out) begin
                if (load) begin
                    word_q <= rd_word;
                end
            end

            assign pop       = load;
            assign out_word  = word_q;
            assign out_valid = valid_q;

        end else begin : pass_g

            //////////////////////////////
            // direct presentation
            //////////////////////////////

            // head goes straight out, pop on each transfer
            assign out_word  = rd_word;
            assign out_valid = !empty;
            assign pop       = out_valid && out_ready;

        end
    endgenerate

endmodule

/* hw/fifo_word_ram.sv */
/* Word store for distributed RAM. Write is registered, read is combinational.
   Contents are undefined after power up and are not cleared by reset. */

`timescale 1ns/1ps

module fifo_word_ram #(
    parameter int DEPTH = 64
) (
    input  logic                      axis_out,

    // write port
    input  logic                      wr_en,
    input  logic [$clog2(DEPTH)-1:0]  wr_ptr,
    input  pkt_fifo_pkg::axis_word_t  wr_word,

    // read port
    input  logic [$clog2(DEPTH)-1:0]  rd_ptr,
    output pkt_fifo_pkg::axis_word_t  rd_word
);
    import pkt_fifo_pkg::*;

    //////////////////////////////
    // storage
    //////////////////////////////

    // lut ram, one beat per entry
    (* ram_style = "distributed" *) axis_word_t mem [DEPTH];

    always_ff @(posedge axis_out) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    //////////////////////////////
    // read
    //////////////////////////////

    // head word, valid whenever the FIFO is not empty
    assign rd_word = mem[rd_ptr];

endmodule

/* hw/pkt_fifo_ctrl.sv */
/* Pointer and flag control for a single clock word FIFO. DEPTH must be a power of two.
   One slot is held back, so at most DEPTH-1 words sit in the RAM. */

`timescale 1ns/1ps

module pkt_fifo_ctrl #(
    parameter int DEPTH              = 64,
    parameter bit ALLOW_BACKPRESSURE = 1'b0
) (
    input  logic                     axis_out,
    input  logic                     reset,

    // write side
    input  logic                     in_valid,
    input  logic                     in_last,
    output logic                     in_ready,
    output logic                     wr_en,
    output logic [$clog2(DEPTH)-1:0] wr_ptr,

    // read side
    input  logic                     pop,
    output logic [$clog2(DEPTH)-1:0] rd_ptr,
    output logic                     empty,

    // loss reporting
    output logic                     in_overflow,
    output logic                     out_overflow
);
    import pkt_fifo_pkg::*;

    localparam int ADDR_W = $clog2(DEPTH);

    // occupancy at which the store counts as full
    localparam logic [ADDR_W-1:0] FULL_LEVEL = ADDR_W'(DEPTH - 1);

    //////////////////////////////
    // declarations
    //////////////////////////////

    drop_state_t       state;
    logic              full;
    logic              accept;
    logic              discard;
    logic [ADDR_W-1:0] wr_ptr_next;
    logic [ADDR_W-1:0] rd_ptr_next;
    logic [ADDR_W-1:0] level_next;

    //////////////////////////////
    // handshake and write decision
    //////////////////////////////

    // without back-pressure the input never stalls
    assign in_ready = !full || !ALLOW_BACKPRESSURE;
    assign accept   = in_valid && in_ready;

    // stored only with room and an intact packet
    assign wr_en   = accept && !full && (state == st_pass);
    assign discard = accept && (full || (state == st_drop));

    //////////////////////////////
    // pointers and full flag
    //////////////////////////////

    assign wr_ptr_next = wr_ptr + ADDR_W'(wr_en);
    assign rd_ptr_next = rd_ptr + ADDR_W'(pop);

    // wraps modulo DEPTH
    assign level_next = wr_ptr_next - rd_ptr_next;

    assign empty = (wr_ptr == rd_ptr);

    always_ff @(posedge axis_out) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full   <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr_next;
            rd_ptr <= rd_ptr_next;
            // full tracks the level after this edge
            full   <= (level_next >= FULL_LEVEL);
        end
    end

    //////////////////////////////
    // packet drop FSM
    //////////////////////////////

    always_ff @(posedge axis_out) begin
        if (reset) begin
            state       <= st_pass;
            in_overflow <= 1'b0;
        end else begin
            // a damaged packet always ends with a discarded last beat
            in_overflow <= discard && in_last;

            case (state)
                st_pass: begin
                    if (discard && !in_last) begin
                        state <= st_drop;
                    end
                end
                st_drop: begin
                    if (accept && in_last) begin
                        state <= st_pass;
                    end
                end
                default: begin
                    state <= st_pass;
                end
            endcase
        end
    end

    // also covers a lone beat lost while full
    assign out_overflow = (state == st_drop) || discard;

endmodule

/* hw/pkt_fifo_pkg.sv */
/* Stream word types shared by the packet FIFO and its testbench.
   DATA_BYTES is fixed for the subsystem and sets the stored word width. */

package pkt_fifo_pkg;

    //////////////////////////////
    // bus geometry
    //////////////////////////////

    // byte lanes per beat
    localparam int DATA_BYTES = 4;

    //////////////////////////////
    // stream beat
    //////////////////////////////

    // one stored beat of 37 bits for four lanes
    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
    } axis_word_t;

    //////////////////////////////
    // write side packet state
    //////////////////////////////

    // st_drop discards beats until the end mark of the damaged packet
    typedef enum logic {
        st_pass = 1'b0,
        st_drop = 1'b1
    } drop_state_t;

endpackage
